// File: div_golden.txt
# Columns in hex: a b quot_sel mod_sel expected_quotient expected_remainder
# Selector 0 means the result is not written
00000064 00000007 01 02 0000000e 00000002
00000fa0 00000028 03 04 00000064 00000000
ffffffff 00000010 05 06 0fffffff 0000000f
12345678 00000000 07 08 ffffffff 12345678
00000005 00000009 00 09 00000000 00000005
deadbeef 00010000 0a 00 0000dead 0000beef
000003e8 00000003 01 0b 0000014d 00000001
00000011 00000005 0c 0c 00000003 00000002
80000000 80000000 0d 0e 00000001 00000000
00000000 00000000 00 00 ffffffff 00000000
fffffffe ffffffff 0f 10 00000000 fffffffe

// File: project.f
div_geom_pkg.sv
div_ctrl_pkg.sv
div_cmd_port.sv
int_div_core.sv
div_writeback.sv
reg_file.sv
int_div_regfile_top.sv
tb_int_div_regfile.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/10ps --top-module tb_int_div_regfile -f project.f
./obj_dir/Vtb_int_div_regfile

// File: tb_int_div_regfile.sv
`timescale 1ns/10ps

module tb_int_div_regfile;
    import div_geom_pkg::*;

    localparam int clk_period     = 100;
    localparam int drive_delay    = 10;
    localparam int reset_cycles   = 5;
    localparam int cycles_per_cmd = 60;
    localparam int slack_cycles   = 100;

    logic                     clk;
    logic                     rst;
    logic                     cmd_req;
    logic                     cmd_ack;
    logic [data_width-1:0]    a;
    logic [data_width-1:0]    b;
    logic [reg_sel_width-1:0] quot_sel;
    logic [reg_sel_width-1:0] mod_sel;
    logic                     busy;
    logic [reg_sel_width-1:0] rd_sel;
    logic [data_width-1:0]    rd_data;

    // Golden vectors, one entry per command
    logic [data_width-1:0]    vec_a [$];
    logic [data_width-1:0]    vec_b [$];
    logic [reg_sel_width-1:0] vec_qs [$];
    logic [reg_sel_width-1:0] vec_ms [$];
    logic [data_width-1:0]    vec_q [$];
    logic [data_width-1:0]    vec_r [$];

    logic [data_width-1:0]    shadow [num_regs];  // Predicted register file
    logic [31:0]              lcg_state;
    int                       num_cmds;

    int_div_regfile_top int_div_regfile_top_inst (
        .clk(clk), .rst(rst), .cmd_req(cmd_req), .cmd_ack(cmd_ack),
        .a(a), .b(b), .quot_sel(quot_sel), .mod_sel(mod_sel),
        .busy(busy), .rd_sel(rd_sel), .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unsigned divide, b of zero gives all ones and a
    function automatic logic [2*data_width-1:0] reference_divide(
        input logic [data_width-1:0] x,
        input logic [data_width-1:0] y
    );
        if (y == '0) return {{data_width{1'b1}}, x};
        return {x / y, x % y};
    endfunction

    task automatic check_value(input logic [data_width-1:0] actual,
                               input logic [data_width-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic load_golden();
        int                    fd;
        int                    count;
        string                 line;
        logic [31:0]           col [6];
        logic [2*data_width-1:0] ref_qr;
        fd = $fopen("div_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open div_golden.txt");
            $display("TB FAILED");
            $fatal(1, "Missing golden file");
        end
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            count = $sscanf(line, "%h %h %h %h %h %h",
                            col[0], col[1], col[2], col[3], col[4], col[5]);
            if (count == 6) begin  // Comment and blank lines fall through
                ref_qr = reference_divide(col[0], col[1]);
                if (ref_qr !== {col[4], col[5]}) begin
                    $display("Golden vector %0d disagrees with the division rule", vec_a.size());
                    $display("TB FAILED");
                    $fatal(1, "Inconsistent golden file");
                end
                vec_a.push_back(col[0]);
                vec_b.push_back(col[1]);
                vec_qs.push_back(reg_sel_width'(col[2]));
                vec_ms.push_back(reg_sel_width'(col[3]));
                vec_q.push_back(col[4]);
                vec_r.push_back(col[5]);
            end
        end
        $fclose(fd);
        if (vec_a.size() == 0) begin
            $display("The golden file holds no vectors");
            $display("TB FAILED");
            $fatal(1, "Empty golden file");
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        for (int i = 0; i < num_regs; i++) begin
            shadow[i] = '0;
        end
    endtask

    task automatic compare_registers(input string tag);
        for (int i = 0; i < num_regs; i++) begin
            rd_sel = reg_sel_width'(i);
            #1;  // Read port is combinational
            check_value(rd_data, shadow[i], $sformatf("%s, register %0d", tag, i));
        end
        next_cycle();
    endtask

    task automatic check_after_reset(input string tag);
        check_value(data_width'(cmd_ack), '0, {tag, ", cmd_ack"});
        check_value(data_width'(busy), '0, {tag, ", busy"});
        compare_registers(tag);
    endtask

    task automatic issue_command(input int v);
        a        = vec_a[v];
        b        = vec_b[v];
        quot_sel = vec_qs[v];
        mod_sel  = vec_ms[v];
        cmd_req  = 1'b1;
        do begin
            next_cycle();
        end while (!cmd_ack);
        next_cycle();  // Req stays up one cycle past the ack
        cmd_req = 1'b0;
        do begin
            next_cycle();
        end while (cmd_ack);
        // Writes land in issue order, remainder after quotient
        if (vec_qs[v] != '0) shadow[vec_qs[v]] = vec_q[v];
        if (vec_ms[v] != '0) shadow[vec_ms[v]] = vec_r[v];
    endtask

    task automatic wait_idle();
        do begin
            next_cycle();
        end while (busy);
    endtask

    initial begin
        rst       = 1'b1;
        cmd_req   = 1'b0;
        a         = '0;
        b         = '0;
        quot_sel  = '0;
        mod_sel   = '0;
        rd_sel    = '0;
        lcg_state = 32'hf8061001;
        num_cmds  = 0;
        load_golden();
        num_cmds = 2 * vec_a.size();  // Isolated pass plus overlapped pass

        apply_reset();
        check_after_reset("first reset");

        // One command at a time
        for (int v = 0; v < vec_a.size(); v++) begin
            issue_command(v);
            wait_idle();
            compare_registers($sformatf("isolated vector %0d", v));
        end

        // Back to back with short random gaps, later writes win
        apply_reset();
        check_after_reset("second reset");
        for (int v = 0; v < vec_a.size(); v++) begin
            issue_command(v);
            lcg_state = lcg_step(lcg_state);
            repeat (lcg_state[17:16]) next_cycle();
        end
        wait_idle();
        compare_registers("overlapped run");

        $display("TB PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        wait (num_cmds > 0);
        repeat (num_cmds * cycles_per_cmd + slack_cycles) @(posedge clk);
        $display("Timeout: the DUT did not finish all commands in time");
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: int_div_regfile_top.sv
`timescale 1ns/10ps

module int_div_regfile_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cmd_req,
    output logic                                cmd_ack,
    input  logic [div_geom_pkg::data_width-1:0]    a,
    input  logic [div_geom_pkg::data_width-1:0]    b,
    input  logic [div_geom_pkg::reg_sel_width-1:0] quot_sel,
    input  logic [div_geom_pkg::reg_sel_width-1:0] mod_sel,
    output logic                                busy,
    input  logic [div_geom_pkg::reg_sel_width-1:0] rd_sel,
    output logic [div_geom_pkg::data_width-1:0]    rd_data
);
    import div_geom_pkg::*;

    // Command port to core
    logic                     start_req, start_ack;
    logic [data_width-1:0]    op_a, op_b;
    logic [reg_sel_width-1:0] op_quot_sel, op_mod_sel;

    // Core to writeback
    logic                     res_req, res_ack;
    logic [data_width-1:0]    res_quot, res_rem;
    logic [reg_sel_width-1:0] res_quot_sel, res_mod_sel;

    // Writeback to register file
    logic                     rf_wr_req, rf_wr_ack;
    logic [reg_sel_width-1:0] rf_wr_sel;
    logic [data_width-1:0]    rf_wr_data;

    logic core_busy, wb_busy;

    div_cmd_port div_cmd_port_inst (
        .clk(clk), .rst(rst), .cmd_req(cmd_req), .cmd_ack(cmd_ack),
        .a(a), .b(b), .quot_sel(quot_sel), .mod_sel(mod_sel),
        .start_req(start_req), .start_ack(start_ack), .op_a(op_a), .op_b(op_b),
        .op_quot_sel(op_quot_sel), .op_mod_sel(op_mod_sel),
        .core_busy(core_busy), .wb_busy(wb_busy), .busy(busy)
    );

    int_div_core int_div_core_inst (
        .clk(clk), .rst(rst), .start_req(start_req), .start_ack(start_ack),
        .op_a(op_a), .op_b(op_b), .op_quot_sel(op_quot_sel), .op_mod_sel(op_mod_sel),
        .res_req(res_req), .res_ack(res_ack), .res_quot(res_quot), .res_rem(res_rem),
        .res_quot_sel(res_quot_sel), .res_mod_sel(res_mod_sel), .core_busy(core_busy)
    );

    div_writeback div_writeback_inst (
        .clk(clk), .rst(rst), .res_req(res_req), .res_ack(res_ack),
        .res_quot(res_quot), .res_rem(res_rem),
        .res_quot_sel(res_quot_sel), .res_mod_sel(res_mod_sel),
        .rf_wr_req(rf_wr_req), .rf_wr_ack(rf_wr_ack), .rf_wr_sel(rf_wr_sel),
        .rf_wr_data(rf_wr_data), .wb_busy(wb_busy)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst(rst), .rf_wr_req(rf_wr_req), .rf_wr_ack(rf_wr_ack),
        .rf_wr_sel(rf_wr_sel), .rf_wr_data(rf_wr_data),
        .rd_sel(rd_sel), .rd_data(rd_data)
    );

endmodule

// File: reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rf_wr_req,
    output logic                                rf_wr_ack,
    input  logic [div_geom_pkg::reg_sel_width-1:0] rf_wr_sel,
    input  logic [div_geom_pkg::data_width-1:0]    rf_wr_data,
    input  logic [div_geom_pkg::reg_sel_width-1:0] rd_sel,
    output logic [div_geom_pkg::data_width-1:0]    rd_data
);
    import div_geom_pkg::*;

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rf_wr_ack <= 1'b0;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (rf_wr_req && !rf_wr_ack) begin
                rf_wr_ack <= 1'b1;
                if (rf_wr_sel != '0) regs[rf_wr_sel] <= rf_wr_data;  // x0 stays zero
            end else if (!rf_wr_req && rf_wr_ack) begin
                rf_wr_ack <= 1'b0;
            end
        end
    end

    // Observation port, no latency
    assign rd_data = regs[rd_sel];

    // New write only after the previous ack has dropped
    a_wr_req_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(rf_wr_req) |-> !rf_wr_ack)
        else $error("rf_wr_req rose while rf_wr_ack still high");

endmodule

// File: div_writeback.sv
`timescale 1ns/10ps

module div_writeback (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                res_req,
    output logic                                res_ack,
    input  logic [div_geom_pkg::data_width-1:0]    res_quot,
    input  logic [div_geom_pkg::data_width-1:0]    res_rem,
    input  logic [div_geom_pkg::reg_sel_width-1:0] res_quot_sel,
    input  logic [div_geom_pkg::reg_sel_width-1:0] res_mod_sel,
    output logic                                rf_wr_req,
    input  logic                                rf_wr_ack,
    output logic [div_geom_pkg::reg_sel_width-1:0] rf_wr_sel,
    output logic [div_geom_pkg::data_width-1:0]    rf_wr_data,
    output logic                                wb_busy
);
    import div_geom_pkg::*;
    import div_ctrl_pkg::*;

    wb_state_e              state;
    logic [data_width-1:0]  quot_q;
    logic [data_width-1:0]  rem_q;
    logic [reg_sel_width-1:0] quot_sel_q;
    logic [reg_sel_width-1:0] mod_sel_q;
    logic                   on_mod;

    assign res_ack    = (state == wb_release);
    assign rf_wr_req  = (state == wb_write_quot) || (state == wb_write_mod);
    assign on_mod     = (state == wb_write_mod) || (state == wb_drop_mod);
    assign rf_wr_sel  = on_mod ? mod_sel_q : quot_sel_q;
    assign rf_wr_data = on_mod ? rem_q : quot_q;
    assign wb_busy    = (state != wb_idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= wb_idle;
        end else begin
            case (state)
                wb_idle: if (res_req) state <= wb_release;
                wb_release: begin
                    // Core is free once res_req drops; zero selectors are skipped
                    if (!res_req) begin
                        if (quot_sel_q != '0) state <= wb_write_quot;
                        else if (mod_sel_q != '0) state <= wb_write_mod;
                        else state <= wb_idle;
                    end
                end
                wb_write_quot: if (rf_wr_ack) state <= wb_drop_quot;
                wb_drop_quot: begin
                    if (!rf_wr_ack) state <= (mod_sel_q != '0) ? wb_write_mod : wb_idle;
                end
                wb_write_mod:  if (rf_wr_ack) state <= wb_drop_mod;
                wb_drop_mod:   if (!rf_wr_ack) state <= wb_idle;
                default:       state <= wb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wb_idle && res_req) begin
            quot_q     <= res_quot;
            rem_q      <= res_rem;
            quot_sel_q <= res_quot_sel;
            mod_sel_q  <= res_mod_sel;
        end
    end

    // Register 0 writes never reach the register file
    a_sel_nonzero: assert property (@(posedge clk) disable iff (rst)
        rf_wr_req |-> rf_wr_sel != '0)
        else $error("Write request to register 0");

endmodule

// File: int_div_core.sv
`timescale 1ns/10ps

module int_div_core (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start_req,
    output logic                                start_ack,
    input  logic [div_geom_pkg::data_width-1:0]    op_a,
    input  logic [div_geom_pkg::data_width-1:0]    op_b,
    input  logic [div_geom_pkg::reg_sel_width-1:0] op_quot_sel,
    input  logic [div_geom_pkg::reg_sel_width-1:0] op_mod_sel,
    output logic                                res_req,
    input  logic                                res_ack,
    output logic [div_geom_pkg::data_width-1:0]    res_quot,
    output logic [div_geom_pkg::data_width-1:0]    res_rem,
    output logic [div_geom_pkg::reg_sel_width-1:0] res_quot_sel,
    output logic [div_geom_pkg::reg_sel_width-1:0] res_mod_sel,
    output logic                                core_busy
);
    import div_geom_pkg::*;
    import div_ctrl_pkg::*;

    core_state_e             state;
    logic [pos_width-1:0]    pos;
    logic [data_width-1:0]   divisor;
    logic [2*data_width-1:0] shifted;
    logic                    fits;
    logic                    take;

    // Divisor aligned to the current quotient bit
    assign shifted   = {{data_width{1'b0}}, divisor} << pos;
    assign fits      = shifted <= {{data_width{1'b0}}, res_rem};  // >= so exact multiples work
    assign take      = (state == core_idle) && start_req && !start_ack;
    assign core_busy = (state != core_idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= core_idle;
            pos       <= '0;
            start_ack <= 1'b0;
            res_req   <= 1'b0;
        end else begin
            if (start_ack && !start_req) start_ack <= 1'b0;  // Finish the start handshake
            case (state)
                core_idle: begin
                    if (take) begin
                        start_ack <= 1'b1;
                        pos       <= pos_width'(data_width - 1);
                        state     <= core_calc;
                    end
                end
                core_calc: begin
                    if (pos == '0) begin
                        res_req <= 1'b1;
                        state   <= core_present;
                    end else begin
                        pos <= pos - 1'b1;
                    end
                end
                core_present: begin
                    if (res_req && res_ack) res_req <= 1'b0;
                    else if (!res_req && !res_ack) state <= core_idle;
                end
                default: state <= core_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            divisor      <= op_b;
            res_rem      <= op_a;
            res_quot     <= '0;
            res_quot_sel <= op_quot_sel;  // Selectors ride with the result
            res_mod_sel  <= op_mod_sel;
        end else if (state == core_calc && fits) begin
            res_rem       <= res_rem - shifted[data_width-1:0];
            res_quot[pos] <= 1'b1;
        end
    end

    a_ops_known: assert property (@(posedge clk) disable iff (rst)
        take |-> !$isunknown({op_a, op_b, op_quot_sel, op_mod_sel}))
        else $error("Unknown operands at capture");

    a_res_stable: assert property (@(posedge clk) disable iff (rst)
        res_req && !res_ack |=> $stable({res_quot, res_rem, res_quot_sel, res_mod_sel}))
        else $error("Result changed while res_req pending");

endmodule

// File: div_cmd_port.sv
`timescale 1ns/10ps

module div_cmd_port (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cmd_req,
    output logic                                cmd_ack,
    input  logic [div_geom_pkg::data_width-1:0]    a,
    input  logic [div_geom_pkg::data_width-1:0]    b,
    input  logic [div_geom_pkg::reg_sel_width-1:0] quot_sel,
    input  logic [div_geom_pkg::reg_sel_width-1:0] mod_sel,
    output logic                                start_req,
    input  logic                                start_ack,
    output logic [div_geom_pkg::data_width-1:0]    op_a,
    output logic [div_geom_pkg::data_width-1:0]    op_b,
    output logic [div_geom_pkg::reg_sel_width-1:0] op_quot_sel,
    output logic [div_geom_pkg::reg_sel_width-1:0] op_mod_sel,
    input  logic                                core_busy,
    input  logic                                wb_busy,
    output logic                                busy
);
    import div_ctrl_pkg::*;

    cmd_state_e state;
    logic       pending;
    logic       take;

    assign take      = (state == cmd_idle) && cmd_req;
    assign cmd_ack   = (state == cmd_hold_ack);
    assign start_req = (state == cmd_hand_off);
    assign pending   = (state != cmd_idle);  // One command buffered here
    assign busy      = pending || core_busy || wb_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cmd_idle;
        end else begin
            case (state)
                cmd_idle:      if (cmd_req) state <= cmd_hold_ack;
                cmd_hold_ack:  if (!cmd_req) state <= cmd_hand_off;
                cmd_hand_off:  if (start_ack) state <= cmd_wait_drop;
                cmd_wait_drop: if (!start_ack) state <= cmd_idle;
                default:       state <= cmd_idle;
            endcase
        end
    end

    // Operands stay put until the core has them
    always_ff @(posedge clk) begin
        if (take) begin
            op_a        <= a;
            op_b        <= b;
            op_quot_sel <= quot_sel;
            op_mod_sel  <= mod_sel;
        end
    end

    // Client must hold req until it gets an ack
    a_cmd_req_held: assert property (@(posedge clk) disable iff (rst)
        cmd_req && !cmd_ack |=> cmd_req)
        else $error("cmd_req dropped before cmd_ack rose");

endmodule

// File: div_ctrl_pkg.sv
package div_ctrl_pkg;

    typedef enum logic [1:0] {
        cmd_idle,      // Ready for a client command
        cmd_hold_ack,  // Ack high, waiting for req to drop
        cmd_wait_drop, // Core took it, waiting for start_ack to drop
        cmd_hand_off   // start_req high towards the core
    } cmd_state_e;

    typedef enum logic [1:0] {
        core_idle,
        core_calc,
        core_present   // Result handshake to writeback
    } core_state_e;

    typedef enum logic [2:0] {
        wb_idle,
        wb_write_quot,
        wb_drop_quot,
        wb_write_mod,
        wb_drop_mod,
        wb_release     // res_ack high until res_req drops
    } wb_state_e;

endpackage

// File: div_geom_pkg.sv
package div_geom_pkg;

    // Operand and result width of the divider
    localparam int data_width = 32;

    // Register file depth, register 0 reads as zero
    localparam int num_regs = 32;

    // Selector into the register file
    localparam int reg_sel_width = $clog2(num_regs);

    // Bit position counter, counts down from data_width - 1
    localparam int pos_width = $clog2(data_width);

endpackage
